// ==== verilog/nes_rom_pkg.sv ====
/*
 * Download bus, iNES header and cartridge memory definitions.
 * Memory map is fixed: PRG from 0, CHR from 0x200000, 4 MB in total.
 */
`default_nettype none

package nes_rom_pkg;

	typedef logic [7:0]  byte_t;         // Download or memory data
	typedef logic [24:0] dl_addr_t;      // Byte offset within a download
	typedef logic [21:0] mem_addr_t;     // Cartridge memory address
	typedef logic [7:0]  file_type_t;    // Host file index
	typedef logic [31:0] mapper_flags_t;

	// Host download bus, one byte per wr cycle
	typedef struct packed {
		logic       active;
		logic       wr;
		dl_addr_t   addr;
		byte_t      data;
		file_type_t file_type;
	} dl_bus_t;

	typedef struct packed {
		logic      wr;
		mem_addr_t addr;
		byte_t     data;
	} mem_wr_t;

	localparam int        HEADER_BYTES   = 16;
	localparam mem_addr_t PRG_BASE       = 22'h000000;
	localparam mem_addr_t CHR_BASE       = 22'h200000;
	localparam int        PRG_PAGE_SHIFT = 14;            // 16 KB pages
	localparam int        CHR_PAGE_SHIFT = 13;            // 8 KB pages

	// "NES" then 0x1A, byte 0 in the top byte
	localparam logic [31:0] INES_MAGIC = {8'h4E, 8'h45, 8'h53, 8'h1A};

	localparam int POST_LOAD_RESET_CYCLES = 255;

endpackage

`default_nettype wire

// ==== verilog/nes_cheat_pkg.sv ====
/*
 * Cheat code layout. Each field is 32 bits; byte order within a
 * field follows the download byte order, lowest byte first.
 */
`default_nettype none

package nes_cheat_pkg;

	localparam int CHEAT_FIELD_BITS = 32;

	typedef struct packed {
		logic [CHEAT_FIELD_BITS-1:0] flags;
		logic [CHEAT_FIELD_BITS-1:0] address;
		logic [CHEAT_FIELD_BITS-1:0] compare;
		logic [CHEAT_FIELD_BITS-1:0] replace;
	} cheat_code_t;

	// Host file index reserved for cheat codes
	localparam logic [7:0] CHEAT_FILE_TYPE = 8'hFF;

endpackage

`default_nettype wire

// ==== verilog/ines_header_parser.sv ====
/*
 * Holds the 16 iNES header bytes and decodes them combinationally.
 * Outputs are only meaningful once all 16 bytes have been written.
 * Trainers are rejected; FDS headers are not recognised.
 */
`timescale 1ns/10ps
`default_nettype none

module ines_header_parser (
	input  logic                       clk,
	input  logic                       reset_nes,
	input  logic                       hdr_wr,
	input  logic [3:0]                 hdr_index,
	input  nes_rom_pkg::byte_t         hdr_byte,
	input  logic                       invert_mirroring,
	output logic                       header_ok,
	output nes_rom_pkg::mem_addr_t     prg_bytes,
	output nes_rom_pkg::mem_addr_t     chr_bytes,
	output nes_rom_pkg::mapper_flags_t flags
);
	import nes_rom_pkg::*;

	// Page count to a 3 bit size code that is 0 for one page or none
	function automatic logic [2:0] size_code(input byte_t pages);
		logic [2:0] code;
		code = 3'd0;
		for (int i = 0; i < 7; i++) begin
			if (pages > (9'd1 << i))
				code = 3'(i + 1);
		end
		return code;
	endfunction

	byte_t      hdr [HEADER_BYTES];
	logic       is_nes20;
	logic       is_dirty;
	logic       tail_nonzero;
	logic [7:0] mapper;
	logic [2:0] prg_size;
	logic [2:0] chr_size;
	logic       chr_ram;
	logic       mirroring;
	byte_t      nes2_byte8;
	logic [3:0] prg_ram_shift;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			for (int i = 0; i < HEADER_BYTES; i++)
				hdr[i] <= 8'h00;
		end else if (hdr_wr) begin
			hdr[hdr_index] <= hdr_byte;
		end
	end

	//////////////////////////////////////// 
	// Header checks

	assign header_ok = ({hdr[0], hdr[1], hdr[2], hdr[3]} == INES_MAGIC) && !hdr[6][2];

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Junk left in bytes 9..15 by old dump tools
	always_comb begin
		tail_nonzero = (hdr[9][7:1] != 7'd0);
		for (int i = 10; i < HEADER_BYTES; i++) begin
			if (hdr[i] != 8'd0)
				tail_nonzero = 1'b1;
		end
	end

	assign is_dirty = !is_nes20 && tail_nonzero;

	//////////////////////////////////////// 
	// Flag word fields

	assign mapper = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};

	assign prg_bytes = mem_addr_t'(hdr[4]) << PRG_PAGE_SHIFT;
	assign chr_bytes = mem_addr_t'(hdr[5]) << CHR_PAGE_SHIFT;
	assign prg_size  = size_code(hdr[4]);
	assign chr_size  = size_code(hdr[5]);
	assign chr_ram   = (hdr[5] == 8'd0); // No CHR ROM pages

	assign mirroring     = hdr[6][0] ^ invert_mirroring;
	assign nes2_byte8    = is_nes20 ? hdr[8] : 8'h00;        // Submapper and mapper MSBs
	assign prg_ram_shift = is_nes20 ? hdr[10][3:0] : 4'h0;   // PRG RAM is 64 << shift

	assign flags = {
		2'b00,
		prg_ram_shift,
		hdr[6][1],      // Battery
		nes2_byte8,
		hdr[6][3],      // Four-screen
		chr_ram,
		mirroring,
		chr_size,
		prg_size,
		mapper
	};

endmodule

`default_nettype wire

// ==== verilog/rom_load_sequencer.sv ====
/*
 * Steps a ROM download through header, PRG and CHR.
 * Bytes past the end of the CHR image are dropped.
 * A start pulse may coincide with byte 0 of the new download.
 */
`timescale 1ns/10ps
`default_nettype none

module rom_load_sequencer (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   start,
	input  logic                   byte_wr,
	input  nes_rom_pkg::byte_t     byte_in,
	input  logic                   header_ok,
	input  nes_rom_pkg::mem_addr_t prg_bytes,
	input  nes_rom_pkg::mem_addr_t chr_bytes,
	output logic                   hdr_wr,
	output logic [3:0]             hdr_index,
	output nes_rom_pkg::mem_wr_t   wr_req,
	output logic                   busy,
	output logic                   done,
	output logic                   error
);
	import nes_rom_pkg::*;

	typedef enum logic [2:0] {
		S_HEADER,
		S_PRG,
		S_CHR,
		S_DONE,
		S_ERROR
	} load_state_t;

	load_state_t state;
	logic [3:0]  hdr_cnt;
	mem_addr_t   addr_cnt;
	mem_addr_t   bytes_left;
	logic        in_image;

	// Start forces header byte 0 in the same cycle
	assign hdr_wr    = byte_wr && (start || state == S_HEADER);
	assign hdr_index = start ? 4'd0 : hdr_cnt;

	assign in_image = !start && (state == S_PRG || state == S_CHR) && (bytes_left != '0);
	assign wr_req   = '{wr: byte_wr && in_image, addr: addr_cnt, data: byte_in};

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= S_HEADER;
			hdr_cnt    <= 4'd0;
			addr_cnt   <= PRG_BASE;
			bytes_left <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else if (start) begin
			state   <= S_HEADER;
			hdr_cnt <= {3'd0, byte_wr};
			busy    <= 1'b0;
			done    <= 1'b0;
			error   <= 1'b0;
		end else begin
			unique case (state)
				S_HEADER: if (byte_wr) begin
					hdr_cnt <= hdr_cnt + 4'd1;
					if (hdr_cnt == 4'(HEADER_BYTES - 1)) begin
						if (header_ok) begin // Parser already holds bytes 0..6
							state      <= S_PRG;
							busy       <= 1'b1;
							addr_cnt   <= PRG_BASE;
							bytes_left <= prg_bytes;
						end else begin
							state <= S_ERROR;
							error <= 1'b1;
							done  <= 1'b1;
						end
					end
				end
				S_PRG, S_CHR: begin
					if (bytes_left != '0) begin
						if (byte_wr) begin
							addr_cnt   <= addr_cnt + 1'b1;
							bytes_left <= bytes_left - 1'b1;
						end
					end else if (state == S_PRG) begin
						state      <= S_CHR;
						addr_cnt   <= CHR_BASE;
						bytes_left <= chr_bytes; // Zero with CHR RAM
					end else begin
						state <= S_DONE;
						busy  <= 1'b0;
						done  <= 1'b1;
					end
				end
				default: ; // Done and error wait for the next start
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mem_write_stager.sv ====
/*
 * One-entry write buffer in front of the slotted cartridge memory.
 * The host must honour dl_wait; a request while one is pending
 * overwrites it.
 */
`timescale 1ns/10ps
`default_nettype none

module mem_write_stager (
	input  logic                 clk,
	input  logic                 reset_nes,
	input  nes_rom_pkg::mem_wr_t wr_req,
	input  logic                 mem_slot,
	output nes_rom_pkg::mem_wr_t mem,
	output logic                 dl_wait
);
	import nes_rom_pkg::*;

	mem_addr_t held_addr;    // Address and data of the pending write
	byte_t     held_data;
	logic      pending;
	logic      fire;

	always_ff @(posedge clk) begin
		if (wr_req.wr) begin
			held_addr <= wr_req.addr;
			held_data <= wr_req.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			pending <= 1'b0;
			fire    <= 1'b0;
		end else begin
			fire <= pending && mem_slot;
			if (wr_req.wr)
				pending <= 1'b1;
			else if (mem_slot)
				pending <= 1'b0;  // Released into this slot
		end
	end

	// Held stays stable through the fire cycle
	assign mem     = '{wr: fire, addr: held_addr, data: held_data};
	assign dl_wait = pending;

endmodule

`default_nettype wire

// ==== verilog/cheat_code_assembler.sv ====
/*
 * Collects 16 download bytes into one cheat code.
 * Byte index wraps, so a longer file yields one code per 16 bytes.
 */
`timescale 1ns/10ps
`default_nettype none

module cheat_code_assembler (
	input  logic                       clk,
	input  logic                       reset_nes,
	input  logic                       byte_wr,
	input  logic [3:0]                 byte_index,
	input  nes_rom_pkg::byte_t         byte_in,
	output nes_cheat_pkg::cheat_code_t cheat_code,
	output logic                       cheat_strobe
);
	import nes_cheat_pkg::*;

	logic [4:0] bit_base;    // Byte position within its field

	assign bit_base = {byte_index[1:0], 3'b000};

	always_ff @(posedge clk) begin
		if (byte_wr) begin
			unique case (byte_index[3:2])
				2'd0: cheat_code.flags[bit_base +: 8]   <= byte_in;
				2'd1: cheat_code.address[bit_base +: 8] <= byte_in;
				2'd2: cheat_code.compare[bit_base +: 8] <= byte_in;
				2'd3: cheat_code.replace[bit_base +: 8] <= byte_in;
				default: ;
			endcase
		end
	end

	// Code is complete once the last replace byte lands
	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_strobe <= 1'b0;
		else
			cheat_strobe <= byte_wr && (byte_index == 4'd15);
	end

endmodule

`default_nettype wire

// ==== verilog/cart_loader.sv ====
/*
 * Cartridge loader top. File type 0xFF goes to the cheat path, every
 * other type is treated as an iNES ROM. Holds the core in reset until
 * the first ROM load and for 255 cycles after each load.
 */
`timescale 1ns/10ps
`default_nettype none

module cart_loader (
	input  logic                       clk,
	input  logic                       reset_nes,
	input  nes_rom_pkg::dl_bus_t       dl,
	output logic                       dl_wait,
	input  logic                       invert_mirroring,
	input  logic                       mem_slot,
	output nes_rom_pkg::mem_wr_t       mem,
	output logic                       busy,
	output logic                       done,
	output logic                       error,
	output nes_rom_pkg::mapper_flags_t mapper_flags,
	output logic                       core_reset,
	output nes_cheat_pkg::cheat_code_t cheat_code,
	output logic                       cheat_strobe
);
	import nes_rom_pkg::*;
	import nes_cheat_pkg::*;

	logic          is_cheat;
	logic          rom_active;
	logic          rom_active_q;
	logic          rom_start;
	logic          hdr_wr;
	logic [3:0]    hdr_index;
	logic          header_ok;
	mem_addr_t     prg_bytes;
	mem_addr_t     chr_bytes;
	mapper_flags_t flags;
	mem_wr_t       wr_req;
	logic          done_q;
	logic          booted;      // First ROM download seen
	logic [7:0]    rst_cnt;

	assign is_cheat   = (dl.file_type == CHEAT_FILE_TYPE);
	assign rom_active = dl.active && !is_cheat;
	assign rom_start  = rom_active && !rom_active_q;

	ines_header_parser parser_inst (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.hdr_wr           (hdr_wr),
		.hdr_index        (hdr_index),
		.hdr_byte         (dl.data),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_bytes        (prg_bytes),
		.chr_bytes        (chr_bytes),
		.flags            (flags)
	);

	rom_load_sequencer sequencer_inst (
		.clk       (clk),
		.reset_nes (reset_nes),
		.start     (rom_start),
		.byte_wr   (dl.wr && rom_active),
		.byte_in   (dl.data),
		.header_ok (header_ok),
		.prg_bytes (prg_bytes),
		.chr_bytes (chr_bytes),
		.hdr_wr    (hdr_wr),
		.hdr_index (hdr_index),
		.wr_req    (wr_req),
		.busy      (busy),
		.done      (done),
		.error     (error)
	);

	mem_write_stager stager_inst (
		.clk       (clk),
		.reset_nes (reset_nes),
		.wr_req    (wr_req),
		.mem_slot  (mem_slot),
		.mem       (mem),
		.dl_wait   (dl_wait)
	);

	cheat_code_assembler cheat_inst (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.byte_wr      (dl.wr && dl.active && is_cheat),
		.byte_index   (dl.addr[3:0]),
		.byte_in      (dl.data),
		.cheat_code   (cheat_code),
		.cheat_strobe (cheat_strobe)
	);

	//////////////////////////////////////// 
	// Flag latch and core reset

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			rom_active_q <= 1'b0;
			done_q       <= 1'b0;
			booted       <= 1'b0;
			rst_cnt      <= 8'd0;
			mapper_flags <= '0;
		end else begin
			rom_active_q <= rom_active;
			done_q       <= done;
			if (rom_active)
				booted <= 1'b1;
			if (done && !done_q && !error)
				mapper_flags <= flags;
			if (rom_active || busy)
				rst_cnt <= 8'(POST_LOAD_RESET_CYCLES); // Restarts until both are low
			else if (rst_cnt != 8'd0)
				rst_cnt <= rst_cnt - 8'd1;
		end
	end

	assign core_reset = !booted || rom_active || busy || error || (rst_cnt != 8'd0);

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
/*
 * Free-running testbench clock, 40 ns period, starts low.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk
);
	localparam int HALF_PERIOD = 20;    // ns

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== verif/cart_loader_assert.sv ====
/*
 * Memory slot and download wait protocol checks, bound into cart_loader.
 * fail_count is read back by the testbench at the end of the run.
 */
`timescale 1ns/10ps
`default_nettype none

module cart_loader_assert (
	input logic                 clk,
	input logic                 reset_nes,
	input logic                 mem_slot,
	input nes_rom_pkg::mem_wr_t mem,
	input logic                 dl_wait,
	input logic                 busy,
	input logic                 done
);
	int fail_count = 0;

	// Write only right after a slot, never two cycles in a row
	wr_after_slot: assert property (@(posedge clk) disable iff (reset_nes)
		mem.wr |-> ($past(mem_slot) && !$past(mem.wr)))
		else begin
			fail_count++;
			$error("mem.wr high outside the cycle after a memory slot");
		end

	// A pending write always goes out in the first slot
	wait_one_slot: assert property (@(posedge clk) disable iff (reset_nes)
		(dl_wait && mem_slot) |=> !dl_wait)
		else begin
			fail_count++;
			$error("dl_wait held across a memory slot");
		end

	busy_not_done: assert property (@(posedge clk) disable iff (reset_nes)
		!(busy && done))
		else begin
			fail_count++;
			$error("busy and done high together");
		end

endmodule

`default_nettype wire

// ==== verif/cart_loader_tb.sv ====
/*
 * Directed testbench for cart_loader with a memory slot every fourth cycle.
 * Image loads stream up to 40 KB each, so a run is about 0.5 M cycles.
 */
`timescale 1ns/10ps
`default_nettype none

module cart_loader_tb;
	import nes_rom_pkg::*;
	import nes_cheat_pkg::*;

	localparam int          WAIT_LIMIT = 2000;    // Cycles allowed per wait loop
	localparam int unsigned SEED       = 32'h733c9d2a;

	logic          clk;
	logic          reset_nes;
	dl_bus_t       dl;
	logic          dl_wait;
	logic          invert_mirroring;
	logic          mem_slot = 1'b0;
	logic [1:0]    slot_phase = 2'd0;
	mem_wr_t       mem;
	logic          busy;
	logic          done;
	logic          error;
	mapper_flags_t mapper_flags;
	logic          core_reset;
	cheat_code_t   cheat_code;
	logic          cheat_strobe;

	byte_t mem_image [int];      // Every write seen on the memory port
	byte_t expect_image [int];
	byte_t hdr [HEADER_BYTES];
	int    mismatches = 0;
	int    failures = 0;
	int    strobe_count = 0;

	tb_clock clock_inst (.clk(clk));

	cart_loader cart_loader_inst (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.dl               (dl),
		.dl_wait          (dl_wait),
		.invert_mirroring (invert_mirroring),
		.mem_slot         (mem_slot),
		.mem              (mem),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags),
		.core_reset       (core_reset),
		.cheat_code       (cheat_code),
		.cheat_strobe     (cheat_strobe)
	);

	bind cart_loader cart_loader_assert assert_inst (
		.clk       (clk),
		.reset_nes (reset_nes),
		.mem_slot  (mem_slot),
		.mem       (mem),
		.dl_wait   (dl_wait),
		.busy      (busy),
		.done      (done)
	);

	always @(negedge clk) begin
		slot_phase <= slot_phase + 2'd1;
		mem_slot   <= (slot_phase == 2'd3);   // One slot in four
	end

	// Write and strobe monitor
	always @(negedge clk) begin
		if (!reset_nes && mem.wr) begin
			if (mem_image.exists(int'(mem.addr))) begin
				$display("Address %h was written twice, at %0t", mem.addr, $time);
				failures++;
			end
			mem_image[int'(mem.addr)] = mem.data;
		end
		if (!reset_nes && cheat_strobe)
			strobe_count++;
	end

	////////////////////////////////////////
	// Helpers

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
		mismatches++;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
		$display("Mismatches: %0d, other failures: %0d", mismatches, failures + 1);
		$display("ERRORS FOUND");
		$finish;
	endtask

	// Size code rises by one per doubling of the page count up to 7
	function automatic logic [2:0] pages_to_code(input int pages);
		int code;
		int reach;
		code  = 0;
		reach = 1;
		while (reach < pages && code < 7) begin
			reach = reach * 2;
			code++;
		end
		return 3'(code);
	endfunction

	function automatic mapper_flags_t expected_flags(input logic invert);
		mapper_flags_t f;
		logic          nes20;
		logic          tail;
		nes20 = (hdr[7][3:2] == 2'b10);
		tail  = (hdr[9][7:1] != 7'd0);
		for (int i = 10; i < HEADER_BYTES; i++)
			tail = tail || (hdr[i] != 8'd0);
		f        = '0;
		f[3:0]   = hdr[6][7:4];
		f[7:4]   = (!nes20 && tail) ? 4'h0 : hdr[7][7:4];  // Dirty header drops the high nibble
		f[10:8]  = pages_to_code(int'(hdr[4]));
		f[13:11] = pages_to_code(int'(hdr[5]));
		f[14]    = hdr[6][0] ^ invert;
		f[15]    = (hdr[5] == 8'd0);
		f[16]    = hdr[6][3];
		f[24:17] = nes20 ? hdr[8] : 8'h00;
		f[25]    = hdr[6][1];
		f[29:26] = nes20 ? hdr[10][3:0] : 4'h0;
		return f;
	endfunction

	task automatic set_header(input byte_t prg, input byte_t chr, input byte_t b6,
			input byte_t b7);
		hdr[0] = 8'h4E;    // "N"
		hdr[1] = 8'h45;
		hdr[2] = 8'h53;
		hdr[3] = 8'h1A;
		hdr[4] = prg;
		hdr[5] = chr;
		hdr[6] = b6;
		hdr[7] = b7;
		for (int i = 8; i < HEADER_BYTES; i++)
			hdr[i] = 8'h00;
	endtask

	task automatic begin_download(input file_type_t ftype);
		dl.file_type = ftype;
		dl.active    = 1'b1;
		@(negedge clk);
	endtask

	task automatic send_byte(input dl_addr_t addr, input byte_t data);
		int cycles;
		cycles = 0;
		while (dl_wait && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (dl_wait)
			abort_on_timeout("dl_wait to fall");
		dl.wr   = 1'b1;
		dl.addr = addr;
		dl.data = data;
		@(negedge clk);
		dl.wr = 1'b0;
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (!done && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!done)
			abort_on_timeout("done");
	endtask

	////////////////////////////////////////
	// Tests

	// Streams hdr plus random PRG and CHR images, then checks memory and flags
	task automatic load_rom();
		int            n_prg;
		int            n_chr;
		int            cycles;
		byte_t         value;
		mapper_flags_t want_flags;
		n_prg      = int'(hdr[4]) << PRG_PAGE_SHIFT;
		n_chr      = int'(hdr[5]) << CHR_PAGE_SHIFT;
		want_flags = expected_flags(invert_mirroring);
		mem_image.delete();
		expect_image.delete();
		begin_download(8'h00);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset at download start", 1, core_reset);
		for (int i = 0; i < HEADER_BYTES; i++)
			send_byte(dl_addr_t'(i), hdr[i]);
		for (int i = 0; i < n_prg + n_chr; i++) begin
			value = byte_t'($urandom);
			if (i < n_prg)
				expect_image[int'(PRG_BASE) + i] = value;
			else
				expect_image[int'(CHR_BASE) + i - n_prg] = value;
			send_byte(dl_addr_t'(HEADER_BYTES + i), value);
		end
		wait_for_done();
		cycles = 0;
		while (dl_wait && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (dl_wait)
			abort_on_timeout("the last image write");
		@(negedge clk);
		dl.active = 1'b0;
		// Busy is already low, so the drop of active starts the hold
		cycles = 0;
		while (core_reset && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (core_reset)
			abort_on_timeout("core_reset to fall");
		if (cycles != POST_LOAD_RESET_CYCLES)
			report_mismatch("core_reset hold cycles", POST_LOAD_RESET_CYCLES, cycles);
		if (done !== 1'b1)
			report_mismatch("done", 1, done);
		if (error !== 1'b0)
			report_mismatch("error", 0, error);
		if (busy !== 1'b0)
			report_mismatch("busy", 0, busy);
		if (mapper_flags !== want_flags)
			report_mismatch("mapper_flags", want_flags, mapper_flags);
		if (mem_image.size() != expect_image.size())
			report_mismatch("write count", expect_image.size(), mem_image.size());
		foreach (expect_image[a]) begin
			if (!mem_image.exists(a)) begin
				$display("No write seen at address %h", a);
				failures++;
			end else if (mem_image[a] !== expect_image[a]) begin
				report_mismatch($sformatf("mem[%h]", a), expect_image[a], mem_image[a]);
			end
		end
	endtask

	task automatic reject_bad_header(input logic trainer);
		mapper_flags_t flags_before;
		int            low_cycles;
		set_header(8'd1, 8'd1, 8'h00, 8'h00);
		if (trainer)
			hdr[6] = 8'h04;
		else
			hdr[3] = 8'h1B;
		flags_before = mapper_flags;
		mem_image.delete();
		begin_download(8'h01);
		for (int i = 0; i < HEADER_BYTES; i++)
			send_byte(dl_addr_t'(i), hdr[i]);
		for (int i = HEADER_BYTES; i < HEADER_BYTES + 8; i++)
			send_byte(dl_addr_t'(i), byte_t'($urandom));  // Image bytes to be ignored
		wait_for_done();
		dl.active  = 1'b0;
		low_cycles = 0;
		repeat (POST_LOAD_RESET_CYCLES + 8) begin
			@(negedge clk);
			if (!core_reset)
				low_cycles++;
		end
		if (low_cycles != 0)
			report_mismatch("core_reset low cycles after error", 0, low_cycles);
		if (error !== 1'b1)
			report_mismatch("error", 1, error);
		if (done !== 1'b1)
			report_mismatch("done", 1, done);
		if (mem_image.size() != 0)
			report_mismatch("write count", 0, mem_image.size());
		if (mapper_flags !== flags_before)
			report_mismatch("mapper_flags", flags_before, mapper_flags);
	endtask

	task automatic check_flag_variants();
		set_header(8'd2, 8'd0, 8'h2A, 8'h58);  // NES 2.0, battery, four-screen
		hdr[8]  = 8'h31;
		hdr[10] = 8'h07;
		load_rom();
		set_header(8'd1, 8'd3, 8'h10, 8'h30);  // iNES 1 with junk in the tail
		hdr[8]  = 8'h12;
		hdr[13] = 8'h44;
		load_rom();
		invert_mirroring = 1'b1;
		set_header(8'd0, 8'd0, 8'h01, 8'h00);
		load_rom();
		invert_mirroring = 1'b0;
	endtask

	task automatic load_cheat();
		logic [31:0] want [4];
		byte_t       value;
		logic [3:0]  status_before;
		logic [3:0]  status_after;
		status_before = {busy, done, error, core_reset};
		mem_image.delete();
		strobe_count = 0;
		begin_download(CHEAT_FILE_TYPE);
		for (int i = 0; i < 16; i++) begin
			value = byte_t'($urandom);
			want[i / 4][8 * (i % 4) +: 8] = value;
			if (dl_wait) begin
				$display("dl_wait raised during a cheat download, at %0t", $time);
				failures++;
			end
			send_byte(dl_addr_t'(i), value);
		end
		repeat (4) @(negedge clk);
		dl.active    = 1'b0;
		@(negedge clk);
		status_after = {busy, done, error, core_reset};
		if (strobe_count != 1)
			report_mismatch("cheat_strobe pulses", 1, strobe_count);
		if (cheat_code.flags !== want[0])
			report_mismatch("cheat_code.flags", want[0], cheat_code.flags);
		if (cheat_code.address !== want[1])
			report_mismatch("cheat_code.address", want[1], cheat_code.address);
		if (cheat_code.compare !== want[2])
			report_mismatch("cheat_code.compare", want[2], cheat_code.compare);
		if (cheat_code.replace !== want[3])
			report_mismatch("cheat_code.replace", want[3], cheat_code.replace);
		if (mem_image.size() != 0)
			report_mismatch("write count", 0, mem_image.size());
		if (status_after !== status_before)
			report_mismatch("busy/done/error/core_reset", status_before, status_after);
	endtask

	initial begin
		void'($urandom(SEED));
		reset_nes        = 1'b1;
		dl               = '0;
		invert_mirroring = 1'b0;
		repeat (10) @(negedge clk);
		reset_nes = 1'b0;
		@(negedge clk);
		if (mem.wr !== 1'b0)
			report_mismatch("mem.wr", 0, mem.wr);
		if ({dl_wait, busy, done, error, cheat_strobe} !== 5'b0)
			report_mismatch("dl_wait/busy/done/error/cheat_strobe", 0,
				{dl_wait, busy, done, error, cheat_strobe});
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", 1, core_reset);
		load_cheat();                          // Before any ROM, core stays in reset
		set_header(8'd1, 8'd1, 8'h11, 8'h40);  // Mapper 0x41, vertical mirroring
		load_rom();
		load_cheat();
		reject_bad_header(1'b0);
		reject_bad_header(1'b1);
		check_flag_variants();
		failures += cart_loader_inst.assert_inst.fail_count;
		$display("Mismatches: %0d, other failures: %0d", mismatches, failures);
		if (mismatches + failures == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/nes_rom_pkg.sv
verilog/nes_cheat_pkg.sv
verilog/ines_header_parser.sv
verilog/rom_load_sequencer.sv
verilog/mem_write_stager.sv
verilog/cheat_code_assembler.sv
verilog/cart_loader.sv
verif/tb_clock.sv
verif/cart_loader_assert.sv
verif/cart_loader_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := cart_loader_tb
RTL_TOP    := cart_loader
FILELIST   := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
RUN_FLAGS  := +verilator+error+limit+1000

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

sim: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
